// ==== ex_pkg.sv ====
/*
  Shared definitions for the RV32I execute stage.
  Widths, control enums, CSR addresses and the request/response structs
  used by every module of the stage and by the testbench.
*/
package ex_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [11:0]     csr_addr_t;

  // Sequential PC increment without compressed instructions
  localparam word_t PC_STEP = 32'd4;

  // Machine-mode CSR numbers
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;
  localparam csr_addr_t CSR_MTVAL    = 12'h343;

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b, alu_csr_set
  } alu_op_e;

  typedef enum logic [3:0] {
    br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu, br_jal, br_jalr
  } br_kind_e;

  typedef enum logic [1:0] {fwd_reg, fwd_ex, fwd_wb} fwd_sel_e;
  typedef enum logic       {src_rs1, src_pc} src_a_e;
  typedef enum logic [1:0] {csr_none, csr_rw, csr_rs, csr_mret} csr_op_e;
  typedef enum logic       {exc_none, exc_instr_misaligned} exc_e;

  // Decoded instruction as handed over by the decode stage
  typedef struct packed {
    word_t     pc;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    src_a_e    src_a;
    logic      imm_b;
    alu_op_e   alu_op;
    br_kind_e  br_kind;
    csr_op_e   csr_op;
    csr_addr_t csr_addr;
  } ex_req_t;

  typedef struct packed {
    logic  valid;
    word_t rd_data;
    logic  redirect;
    word_t target;
    exc_e  exc;
  } ex_rsp_t;

  typedef struct packed {
    logic  valid;
    word_t cause;
    word_t tval;
    word_t epc;
  } trap_t;

endpackage

// ==== ex_alu.sv ====
/*
  Integer ALU of the execute stage, purely combinational.
  Comparison flags come from a subtractor that runs for every operation,
  so the branch unit can use them whatever op is selected.
*/
`timescale 1ns/1ns
module ex_alu (
  input  ex_pkg::word_t   a_i,
  input  ex_pkg::word_t   b_i,
  input  ex_pkg::alu_op_e op_i,
  output ex_pkg::word_t   result_o,
  output logic            zero_o,
  output logic            lt_o,
  output logic            ltu_o
);
  import ex_pkg::*;

  logic [XLEN:0] diff;
  logic [4:0]    shamt;

  // Extra MSB of the difference is the unsigned borrow
  assign diff  = {1'b0, a_i} - {1'b0, b_i};
  assign shamt = b_i[4:0];

  assign zero_o = (diff[XLEN-1:0] == '0);
  assign ltu_o  = diff[XLEN];
  // With differing signs A is less exactly when it is negative
  assign lt_o   = (a_i[XLEN-1] ^ b_i[XLEN-1]) ? a_i[XLEN-1] : diff[XLEN-1];

  always_comb begin
    case (op_i)
      alu_add:     result_o = a_i + b_i;
      alu_sub:     result_o = diff[XLEN-1:0];
      alu_sll:     result_o = a_i << shamt;
      alu_slt:     result_o = {{(XLEN-1){1'b0}}, lt_o};
      alu_sltu:    result_o = {{(XLEN-1){1'b0}}, ltu_o};
      alu_xor:     result_o = a_i ^ b_i;
      alu_srl:     result_o = a_i >> shamt;
      alu_sra:     result_o = word_t'($signed(a_i) >>> shamt);
      alu_or:      result_o = a_i | b_i;
      alu_and:     result_o = a_i & b_i;
      alu_pass_b:  result_o = b_i;
      // B carries the old CSR value here
      alu_csr_set: result_o = a_i | b_i;
      default:     result_o = '0;
    endcase
  end

endmodule

// ==== ex_branch_unit.sv ====
/*
  Branch and jump resolution for the execute stage.
  Decides the redirect from the ALU flags, forms the target and flags a
  target that is not word aligned.
*/
`timescale 1ns/1ns
module ex_branch_unit (
  input  ex_pkg::br_kind_e kind_i,
  input  logic             is_mret_i,
  input  logic             zero_i,
  input  logic             lt_i,
  input  logic             ltu_i,
  input  ex_pkg::word_t    pc_i,
  input  ex_pkg::word_t    rs1_i,
  input  ex_pkg::word_t    imm_i,
  input  ex_pkg::word_t    mepc_i,
  output logic             redirect_o,
  output ex_pkg::word_t    target_o,
  output ex_pkg::exc_e     exc_o
);
  import ex_pkg::*;

  logic taken;

  always_comb begin
    case (kind_i)
      br_beq:          taken = zero_i;
      br_bne:          taken = !zero_i;
      br_blt:          taken = lt_i;
      br_bge:          taken = !lt_i;
      br_bltu:         taken = ltu_i;
      br_bgeu:         taken = !ltu_i;
      br_jal, br_jalr: taken = 1'b1;
      default:         taken = 1'b0;
    endcase
  end

  assign redirect_o = taken | is_mret_i;

  always_comb begin
    if (is_mret_i) begin
      target_o = mepc_i;
    end else if (kind_i == br_jalr) begin
      target_o = (rs1_i + imm_i) & ~word_t'(1);
    end else begin
      target_o = pc_i + imm_i;
    end
  end

  // Without the C extension a taken target needs bit 1 clear
  assign exc_o = (redirect_o && target_o[1]) ? exc_instr_misaligned : exc_none;

endmodule

// ==== ex_csr_file.sv ====
/*
  Machine-mode CSR file: mstatus (MIE/MPIE), mtvec, mepc, mcause, mtval
  and mscratch. Reads are combinational and return the old value; writes,
  trap entry and mret take effect at the clock edge.
*/
`timescale 1ns/1ns
module ex_csr_file (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              we_i,
  input  ex_pkg::csr_op_e   op_i,
  input  ex_pkg::csr_addr_t addr_i,
  input  ex_pkg::word_t     wdata_i,
  input  ex_pkg::trap_t     trap_i,
  output ex_pkg::word_t     rdata_o,
  output ex_pkg::word_t     mepc_o,
  output ex_pkg::word_t     mtvec_o
);
  import ex_pkg::*;

  logic  mie;
  logic  mpie;
  word_t mtvec;
  word_t mepc;
  word_t mcause;
  word_t mtval;
  word_t mscratch;
  word_t mstatus;

  localparam word_t ALIGN_MASK = ~word_t'(3);

  // Only MIE and MPIE are implemented in mstatus
  always_comb begin
    mstatus                   = '0;
    mstatus[MSTATUS_MIE_BIT]  = mie;
    mstatus[MSTATUS_MPIE_BIT] = mpie;
  end

  always_comb begin
    case (addr_i)
      CSR_MSTATUS:  rdata_o = mstatus;
      CSR_MTVEC:    rdata_o = mtvec;
      CSR_MEPC:     rdata_o = mepc;
      CSR_MCAUSE:   rdata_o = mcause;
      CSR_MTVAL:    rdata_o = mtval;
      CSR_MSCRATCH: rdata_o = mscratch;
      default:      rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mie      <= 1'b0;
      mpie     <= 1'b0;
      mtvec    <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
      mscratch <= '0;
    end else if (trap_i.valid) begin
      // Trap entry overrides any CSR access in the same cycle
      mepc   <= trap_i.epc & ALIGN_MASK;
      mcause <= trap_i.cause;
      mtval  <= trap_i.tval;
      mpie   <= mie;
      mie    <= 1'b0;
    end else if (op_i == csr_mret) begin
      mie  <= mpie;
      mpie <= 1'b1;
    end else if (we_i) begin
      case (addr_i)
        CSR_MSTATUS: begin
          mie  <= wdata_i[MSTATUS_MIE_BIT];
          mpie <= wdata_i[MSTATUS_MPIE_BIT];
        end
        CSR_MTVEC:    mtvec    <= wdata_i & ALIGN_MASK;
        CSR_MEPC:     mepc     <= wdata_i & ALIGN_MASK;
        CSR_MCAUSE:   mcause   <= wdata_i;
        CSR_MTVAL:    mtval    <= wdata_i;
        CSR_MSCRATCH: mscratch <= wdata_i;
        default: ;
      endcase
    end
  end

  assign mepc_o  = mepc;
  assign mtvec_o = mtvec;

endmodule

// ==== execution.sv ====
/*
  Combinational execute datapath. Selects forwarded operands, drives the
  ALU, branch unit and CSR file, and forms the next EX/MEM response.
*/
`timescale 1ns/1ns
module execution (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            valid_i,
  input  ex_pkg::ex_req_t req_i,
  input  ex_pkg::word_t   ex_fwd_i,
  input  ex_pkg::word_t   wb_data_i,
  input  ex_pkg::trap_t   trap_i,
  output ex_pkg::ex_rsp_t rsp_o,
  output ex_pkg::word_t   mtvec_o
);
  import ex_pkg::*;

  word_t   rs1_val, rs2_val;
  word_t   op_a, op_b, alu_b;
  word_t   alu_result, csr_rdata, csr_wdata, mepc, target;
  logic    zero, lt, ltu, redirect, is_csr, csr_we;
  csr_op_e csr_op;
  exc_e    exc;

  // Forwarding muxes
  always_comb begin
    case (req_i.fwd_a)
      fwd_ex:  rs1_val = ex_fwd_i;
      fwd_wb:  rs1_val = wb_data_i;
      default: rs1_val = req_i.rs1_data;
    endcase
    case (req_i.fwd_b)
      fwd_ex:  rs2_val = ex_fwd_i;
      fwd_wb:  rs2_val = wb_data_i;
      default: rs2_val = req_i.rs2_data;
    endcase
  end

  assign op_a  = (req_i.src_a == src_pc) ? req_i.pc : rs1_val;
  assign op_b  = req_i.imm_b ? req_i.imm : rs2_val;
  // csrrs ORs operand A into the old CSR value
  assign alu_b = (req_i.csr_op == csr_rs) ? csr_rdata : op_b;

  assign is_csr    = (req_i.csr_op == csr_rw) || (req_i.csr_op == csr_rs);
  assign csr_we    = valid_i && is_csr;
  assign csr_op    = valid_i ? req_i.csr_op : csr_none;
  assign csr_wdata = (req_i.csr_op == csr_rw) ? op_a : alu_result;

  ex_alu u_alu (
    .a_i(op_a), .b_i(alu_b), .op_i(req_i.alu_op),
    .result_o(alu_result), .zero_o(zero), .lt_o(lt), .ltu_o(ltu)
  );

  ex_branch_unit u_branch (
    .kind_i(req_i.br_kind), .is_mret_i(req_i.csr_op == csr_mret),
    .zero_i(zero), .lt_i(lt), .ltu_i(ltu),
    .pc_i(req_i.pc), .rs1_i(op_a), .imm_i(req_i.imm), .mepc_i(mepc),
    .redirect_o(redirect), .target_o(target), .exc_o(exc)
  );

  ex_csr_file u_csr (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .we_i(csr_we), .op_i(csr_op),
    .addr_i(req_i.csr_addr), .wdata_i(csr_wdata), .trap_i(trap_i),
    .rdata_o(csr_rdata), .mepc_o(mepc), .mtvec_o(mtvec_o)
  );

  always_comb begin
    rsp_o.valid = valid_i;
    if (is_csr) begin
      rsp_o.rd_data = csr_rdata;
    end else if ((req_i.br_kind == br_jal) || (req_i.br_kind == br_jalr)) begin
      rsp_o.rd_data = req_i.pc + PC_STEP;
    end else begin
      rsp_o.rd_data = alu_result;
    end
    // Idle cycles never redirect or fault
    rsp_o.redirect = valid_i && redirect;
    rsp_o.target   = target;
    rsp_o.exc      = valid_i ? exc : exc_none;
  end

endmodule

// ==== ex_stage.sv ====
/*
  Top of the execute stage. Holds the EX/MEM response register, which is
  also the forwarding source for the next instruction. One cycle latency,
  no back-pressure.
*/
`timescale 1ns/1ns
module ex_stage (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            valid_i,
  input  ex_pkg::ex_req_t req_i,
  input  ex_pkg::word_t   wb_data_i,
  input  ex_pkg::trap_t   trap_i,
  output ex_pkg::ex_rsp_t rsp_o,
  output ex_pkg::word_t   mtvec_o
);
  import ex_pkg::*;

  ex_rsp_t rsp_d;
  ex_rsp_t rsp_q;

  execution u_execution (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .req_i    (req_i),
    .ex_fwd_i (rsp_q.rd_data),
    .wb_data_i(wb_data_i),
    .trap_i   (trap_i),
    .rsp_o    (rsp_d),
    .mtvec_o  (mtvec_o)
  );

  // EX/MEM response register
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_q <= '0;
    end else begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_o = rsp_q;

endmodule

// ==== tb_ex_stage.sv ====
/*
  Testbench for the execute stage. Builds a table of decoded instructions,
  idle cycles and trap strobes, applies it on falling clock edges and checks
  each response one cycle later against a reference model with shadow CSRs.
*/
`timescale 1ns/1ns
module tb_ex_stage;
  import ex_pkg::*;

  typedef enum logic {step_idle, step_instr} step_kind_e;

  typedef struct packed {
    step_kind_e kind;
    ex_req_t    req;
    word_t      wb;
    trap_t      trap;
  } step_t;

  logic    clk_i, arst_n_i, valid_i;
  ex_req_t req_i;
  word_t   wb_data_i, mtvec_o;
  trap_t   trap_i;
  ex_rsp_t rsp_o;

  step_t   steps[$];
  ex_rsp_t expected;
  int      errors, timeouts;
  // Reference model state
  logic    s_mie, s_mpie;
  word_t   s_mtvec, s_mepc, s_mcause, s_mtval, s_mscratch, last_rd;

  ex_stage uut (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .valid_i(valid_i), .req_i(req_i),
    .wb_data_i(wb_data_i), .trap_i(trap_i), .rsp_o(rsp_o), .mtvec_o(mtvec_o)
  );

  always #5 clk_i = ~clk_i;

  initial begin
    clk_i    = 1'b0;
    arst_n_i = 1'b0;
    repeat (8) @(negedge clk_i);
    arst_n_i = 1'b1;
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_exc(input string name, input exc_e exp, input exc_e act);
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected %s got %s", $time, name, exp.name(), act.name());
    end
  endtask

  function automatic word_t alu_ref(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      alu_add:    return a + b;
      alu_sub:    return a - b;
      alu_sll:    return a << b[4:0];
      alu_slt:    return word_t'($signed(a) < $signed(b));
      alu_sltu:   return word_t'(a < b);
      alu_xor:    return a ^ b;
      alu_srl:    return a >> b[4:0];
      alu_sra:    return word_t'($signed(a) >>> b[4:0]);
      alu_and:    return a & b;
      alu_pass_b: return b;
      default:    return a | b;
    endcase
  endfunction

  function automatic word_t csr_value(input csr_addr_t addr);
    case (addr)
      CSR_MSTATUS:  return (word_t'(s_mpie) << MSTATUS_MPIE_BIT) |
                           (word_t'(s_mie) << MSTATUS_MIE_BIT);
      CSR_MTVEC:    return s_mtvec;
      CSR_MEPC:     return s_mepc;
      CSR_MCAUSE:   return s_mcause;
      CSR_MTVAL:    return s_mtval;
      CSR_MSCRATCH: return s_mscratch;
      default:      return '0;
    endcase
  endfunction

  task automatic csr_write(input csr_addr_t addr, input word_t v);
    case (addr)
      CSR_MSTATUS: begin
        s_mie  = v[MSTATUS_MIE_BIT];
        s_mpie = v[MSTATUS_MPIE_BIT];
      end
      CSR_MTVEC:    s_mtvec    = v & ~32'h3;
      CSR_MEPC:     s_mepc     = v & ~32'h3;
      CSR_MCAUSE:   s_mcause   = v;
      CSR_MTVAL:    s_mtval    = v;
      CSR_MSCRATCH: s_mscratch = v;
      default: ;
    endcase
  endtask

  task automatic model_step(input step_t s, output ex_rsp_t exp);
    ex_req_t q;
    word_t   rs1, rs2, a, b, old;
    logic    taken;
    q    = s.req;
    exp  = '0;
    rs1  = (q.fwd_a == fwd_ex) ? last_rd : ((q.fwd_a == fwd_wb) ? s.wb : q.rs1_data);
    rs2  = (q.fwd_b == fwd_ex) ? last_rd : ((q.fwd_b == fwd_wb) ? s.wb : q.rs2_data);
    a    = (q.src_a == src_pc) ? q.pc : rs1;
    b    = q.imm_b ? q.imm : rs2;
    old  = csr_value(q.csr_addr);
    if (s.kind == step_instr) begin
      case (q.br_kind)
        br_beq:          taken = (a == b);
        br_bne:          taken = (a != b);
        br_blt:          taken = ($signed(a) < $signed(b));
        br_bge:          taken = ($signed(a) >= $signed(b));
        br_bltu:         taken = (a < b);
        br_bgeu:         taken = (a >= b);
        br_jal, br_jalr: taken = 1'b1;
        default:         taken = (q.csr_op == csr_mret);
      endcase
      exp.valid    = 1'b1;
      exp.redirect = taken;
      if (q.csr_op == csr_mret) exp.target = s_mepc;
      else if (q.br_kind == br_jalr) exp.target = (a + q.imm) & ~32'h1;
      else exp.target = q.pc + q.imm;
      exp.exc = (taken && exp.target[1]) ? exc_instr_misaligned : exc_none;
      if (q.csr_op == csr_rw || q.csr_op == csr_rs) exp.rd_data = old;
      else if (q.br_kind == br_jal || q.br_kind == br_jalr) exp.rd_data = q.pc + 32'd4;
      else exp.rd_data = alu_ref(q.alu_op, a, b);
      last_rd = exp.rd_data;
    end
    // Trap entry beats mret and CSR writes
    if (s.trap.valid) begin
      s_mepc   = s.trap.epc & ~32'h3;
      s_mcause = s.trap.cause;
      s_mtval  = s.trap.tval;
      s_mpie   = s_mie;
      s_mie    = 1'b0;
    end else if (s.kind == step_instr && q.csr_op == csr_mret) begin
      s_mie  = s_mpie;
      s_mpie = 1'b1;
    end else if (s.kind == step_instr && q.csr_op == csr_rw) begin
      csr_write(q.csr_addr, a);
    end else if (s.kind == step_instr && q.csr_op == csr_rs) begin
      csr_write(q.csr_addr, a | old);
    end
  endtask

  function automatic step_t mk(input alu_op_e op, input word_t a, input word_t b,
                               input br_kind_e br, input word_t imm,
                               input csr_op_e cop, input csr_addr_t addr);
    step_t s;
    s              = '0;
    s.kind         = step_instr;
    s.req.pc       = $urandom & 32'h000f_fffc;
    s.req.rs1_data = a;
    s.req.rs2_data = b;
    s.req.imm      = imm;
    s.req.alu_op   = op;
    s.req.br_kind  = br;
    s.req.csr_op   = cop;
    s.req.csr_addr = addr;
    return s;
  endfunction

  // csrrs with a zero mask reads without changing the register
  function automatic step_t csr_read(input csr_addr_t addr);
    return mk(alu_csr_set, '0, '0, br_none, '0, csr_rs, addr);
  endfunction

  task automatic build_table();
    step_t s;
    trap_t t;
    word_t r;
    for (int op = 0; op <= int'(alu_pass_b); op++) begin
      s = mk(alu_op_e'(op), $urandom, $urandom, br_none, $urandom, csr_none, '0);
      steps.push_back(s);
      s.req.imm_b = 1'b1;
      steps.push_back(s);
      s.req.src_a = src_pc;
      steps.push_back(s);
    end
    // Equal, signed-less and unsigned-less pairs
    for (int k = int'(br_beq); k <= int'(br_bgeu); k++) begin
      r = $urandom;
      steps.push_back(mk(alu_sub, r, r, br_kind_e'(k), $urandom & 32'hfffc, csr_none, '0));
      steps.push_back(mk(alu_sub, r | 32'h8000_0000, r & 32'h7fff_ffff, br_kind_e'(k),
                         $urandom & 32'hfffc, csr_none, '0));
      steps.push_back(mk(alu_sub, r & 32'h7fff_ffff, r | 32'h8000_0000, br_kind_e'(k),
                         $urandom & 32'hfffc, csr_none, '0));
    end
    steps.push_back(mk(alu_sub, r, r, br_beq, 32'h0000_0042, csr_none, '0));
    // Misaligned target of a branch that is not taken
    steps.push_back(mk(alu_sub, r, r, br_bne, 32'h0000_0042, csr_none, '0));
    steps.push_back(mk(alu_add, r, r, br_jal, 32'h0000_0100, csr_none, '0));
    steps.push_back(mk(alu_add, 32'h0000_2001, r, br_jalr, 32'h0000_0010, csr_none, '0));
    steps.push_back(mk(alu_add, 32'h0000_2003, r, br_jalr, '0, csr_none, '0));
    // Forwarding from EX/MEM and write-back
    steps.push_back(mk(alu_add, $urandom, $urandom, br_none, '0, csr_none, '0));
    s = mk(alu_xor, $urandom, $urandom, br_none, '0, csr_none, '0);
    s.req.fwd_a = fwd_ex;
    steps.push_back(s);
    s = mk(alu_sub, $urandom, $urandom, br_none, '0, csr_none, '0);
    s.req.fwd_a = fwd_wb;
    s.req.fwd_b = fwd_ex;
    s.wb        = $urandom;
    steps.push_back(s);
    s = mk(alu_and, $urandom, $urandom, br_none, '0, csr_none, '0);
    s.req.fwd_b = fwd_wb;
    s.wb        = $urandom;
    steps.push_back(s);
    steps.push_back(mk(alu_add, $urandom, '0, br_none, '0, csr_rw, CSR_MSCRATCH));
    steps.push_back(mk(alu_csr_set, $urandom, '0, br_none, '0, csr_rs, CSR_MSCRATCH));
    steps.push_back(csr_read(CSR_MSCRATCH));
    steps.push_back(mk(alu_add, $urandom, '0, br_none, '0, csr_rw, CSR_MTVEC));
    steps.push_back(csr_read(CSR_MTVEC));
    steps.push_back(mk(alu_add, 32'h0000_0008, '0, br_none, '0, csr_rw, CSR_MSTATUS));
    // Idle, then trap entry, readback and mret
    s = '0;
    steps.push_back(s);
    t.valid = 1'b1;
    t.cause = $urandom & 32'h1f;
    t.tval  = $urandom;
    t.epc   = $urandom;
    s.trap  = t;
    steps.push_back(s);
    steps.push_back(csr_read(CSR_MEPC));
    steps.push_back(csr_read(CSR_MCAUSE));
    steps.push_back(csr_read(CSR_MTVAL));
    steps.push_back(csr_read(CSR_MSTATUS));
    steps.push_back(mk(alu_add, '0, '0, br_none, '0, csr_mret, '0));
    steps.push_back(csr_read(CSR_MSTATUS));
    // Trap in the same cycle as a CSR write
    s = mk(alu_add, $urandom, '0, br_none, '0, csr_rw, CSR_MSCRATCH);
    s.trap = t;
    steps.push_back(s);
    steps.push_back(csr_read(CSR_MSCRATCH));
    s = '0;
    steps.push_back(s);
    steps.push_back(s);
  endtask

  task automatic wait_reset(output logic ok);
    int cycles;
    cycles = 0;
    while (arst_n_i !== 1'b1 && cycles < 50) begin
      @(posedge clk_i);
      cycles++;
    end
    ok = (arst_n_i === 1'b1);
  endtask

  task automatic check_rsp(input ex_rsp_t exp);
    check_bit("rsp_o.valid", exp.valid, rsp_o.valid);
    check_bit("rsp_o.redirect", exp.redirect, rsp_o.redirect);
    check_exc("rsp_o.exc", exp.exc, rsp_o.exc);
    if (exp.valid) check_word("rsp_o.rd_data", exp.rd_data, rsp_o.rd_data);
    if (exp.redirect) check_word("rsp_o.target", exp.target, rsp_o.target);
    check_word("mtvec_o", s_mtvec, mtvec_o);
  endtask

  initial begin
    logic ok;
    void'($urandom(32'h8e478f0d));
    valid_i   = 1'b0;
    req_i     = '0;
    wb_data_i = '0;
    trap_i    = '0;
    {s_mie, s_mpie, s_mtvec, s_mepc, s_mcause, s_mtval, s_mscratch, last_rd} = '0;
    build_table();
    wait_reset(ok);
    if (!ok) begin
      timeouts++;
      $display("ERROR: reset was not released within 50 clock cycles");
    end else begin
      @(negedge clk_i);
      expected = '0;
      check_rsp(expected);
      foreach (steps[i]) begin
        valid_i   = (steps[i].kind == step_instr);
        req_i     = steps[i].req;
        wb_data_i = steps[i].wb;
        trap_i    = steps[i].trap;
        model_step(steps[i], expected);
        @(negedge clk_i);
        check_rsp(expected);
      end
    end
    $display("Steps: %0d, errors: %0d, timeouts: %0d", steps.size(), errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
ex_pkg.sv
ex_alu.sv
ex_branch_unit.sv
ex_csr_file.sv
execution.sv
ex_stage.sv
tb_ex_stage.sv

// ==== Makefile ====
TOP := tb_ex_stage

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f all.f

sim:
	verilator --binary -j 0 --top-module $(TOP) -f all.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
